/* common/fpk_pkg.sv */
// Binary32 types and pipeline latencies for the kernel. NaN and infinity operands are not supported
`default_nettype none

package fpk_pkg;

	// binary32 field widths
	localparam int EXP_W = 8;
	localparam int FRAC_W = 23;
	localparam int MANT_W = FRAC_W + 1;
	localparam int EXP_BIAS = 127;
	localparam int EXP_INF = 255;

	// signed working exponent, wide enough for overflow and underflow
	localparam int SEXP_W = EXP_W + 2;

	// adder mantissa plus guard, round and sticky
	localparam int EXT_W = MANT_W + 3;

	// unit latencies in clock cycles
	localparam int ADD_LAT = 3;
	localparam int MUL_LAT = 2;

	// longest path is mul, add, add, mul, with the first mul hidden under the first add
	localparam int KERNEL_LAT = 2 * ADD_LAT + MUL_LAT;

	localparam int COUNT_W = 32;

	typedef struct packed {
		logic              sign;
		logic [EXP_W-1:0]  exp;
		logic [FRAC_W-1:0] frac;
	} fp_t;

	// one input sample of the five operand streams
	typedef struct packed {
		fp_t in1;
		fp_t in2;
		fp_t in3;
		fp_t in4;
		fp_t in5;
	} fp_sample_t;

	// the four results that leave together
	typedef struct packed {
		fp_t result_1;
		fp_t result_2;
		fp_t result_3;
		fp_t result_4;
	} fp_result_t;

endpackage

`default_nettype wire

/* design/delay_line.sv */
// Delays one binary32 value by DEPTH clock cycles. DEPTH must be at least 1 and the stages have no reset
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
	parameter int DEPTH = 2
) (
	input  wire          clock,
	input  wire          arst_n,
	input  wire  fpk_pkg::fp_t din,
	output fpk_pkg::fp_t dout
);
	import fpk_pkg::*;

	fp_t stage [DEPTH];

	always_ff @(posedge clock)
	begin
		stage[0] <= din;
		for (int i = 1; i < DEPTH; i++)
			stage[i] <= stage[i-1];
	end

	assign dout = stage[DEPTH-1];

endmodule

`default_nettype wire

/* design/dfg_kernel.sv */
// Fixed floating-point dataflow graph. No back-pressure, so the consumer must take every out_valid pulse
`timescale 1ns/1ps
`default_nettype none

module dfg_kernel (
	input  wire                         clock,
	input  wire                         arst_n,
	input  wire                         in_valid,
	input  wire  fpk_pkg::fp_sample_t   sample,
	output fpk_pkg::fp_result_t         result,
	output logic                        out_valid,
	output logic                        busy,
	output logic [fpk_pkg::COUNT_W-1:0] sample_count
);
	import fpk_pkg::*;

	fp_t x1;
	fp_t x2;
	fp_t x3;
	fp_t x4;
	fp_t add1;
	fp_t add2;
	fp_t add3;
	fp_t add4;
	fp_t add5;
	fp_t in1_d;
	fp_t x1_d;
	fp_t add3_d;
	fp_t add4_d;
	fp_t x4_d;

	// in3 * in1 * in1 chain
	fpu_mul u_x3 (.clock(clock), .arst_n(arst_n), .opa(sample.in3), .opb(sample.in1),
		.product(x3));
	delay_line #(.DEPTH(MUL_LAT)) u_in1_dly (.clock(clock), .arst_n(arst_n),
		.din(sample.in1), .dout(in1_d));
	fpu_mul u_x1 (.clock(clock), .arst_n(arst_n), .opa(x3), .opb(in1_d), .product(x1));
	// x1 is ready two cycles before add2
	delay_line #(.DEPTH(2 * ADD_LAT - 2 * MUL_LAT)) u_x1_dly (.clock(clock),
		.arst_n(arst_n), .din(x1), .dout(x1_d));

	// (in5 + in4) + (in2 + in4)
	fpu_add u_add1 (.clock(clock), .arst_n(arst_n), .opa(sample.in2), .opb(sample.in4),
		.sum(add1));
	fpu_add u_add5 (.clock(clock), .arst_n(arst_n), .opa(sample.in5), .opb(sample.in4),
		.sum(add5));
	fpu_add u_add2 (.clock(clock), .arst_n(arst_n), .opa(add5), .opb(add1), .sum(add2));

	fpu_mul u_x2 (.clock(clock), .arst_n(arst_n), .opa(x1_d), .opb(add2), .product(x2));

	// short paths padded out to the kernel latency
	fpu_add u_add3 (.clock(clock), .arst_n(arst_n), .opa(sample.in1), .opb(sample.in2),
		.sum(add3));
	delay_line #(.DEPTH(KERNEL_LAT - ADD_LAT)) u_add3_dly (.clock(clock), .arst_n(arst_n),
		.din(add3), .dout(add3_d));
	fpu_add u_add4 (.clock(clock), .arst_n(arst_n), .opa(sample.in5), .opb(sample.in3),
		.sum(add4));
	delay_line #(.DEPTH(KERNEL_LAT - ADD_LAT)) u_add4_dly (.clock(clock), .arst_n(arst_n),
		.din(add4), .dout(add4_d));
	fpu_mul u_x4 (.clock(clock), .arst_n(arst_n), .opa(sample.in5), .opb(sample.in4),
		.product(x4));
	delay_line #(.DEPTH(KERNEL_LAT - MUL_LAT)) u_x4_dly (.clock(clock), .arst_n(arst_n),
		.din(x4), .dout(x4_d));

	kernel_control u_control (
		.clock        (clock),
		.arst_n       (arst_n),
		.in_valid     (in_valid),
		.out_valid    (out_valid),
		.busy         (busy),
		.sample_count (sample_count)
	);

	assign result = '{result_1: x2, result_2: add3_d, result_3: add4_d, result_4: x4_d};

endmodule

`default_nettype wire

/* design/kernel_control.sv */
// Valid tracking for the kernel. Assumes every accepted sample leaves after KERNEL_LAT cycles with no stall
`timescale 1ns/1ps
`default_nettype none

module kernel_control (
	input  wire                         clock,
	input  wire                         arst_n,
	input  wire                         in_valid,
	output logic                        out_valid,
	output logic                        busy,
	output logic [fpk_pkg::COUNT_W-1:0] sample_count
);
	import fpk_pkg::*;

	// one token per sample in flight
	logic [KERNEL_LAT-1:0] token;

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
			token <= '0;
		else
			token <= {token[KERNEL_LAT-2:0], in_valid};
	end

	assign out_valid = token[KERNEL_LAT-1];
	assign busy = |token;

	// completed samples
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
			sample_count <= '0;
		else if (out_valid)
			sample_count <= sample_count + COUNT_W'(1);
	end

	// a result can only appear from a token that was already in flight
	out_needs_busy: assert property (@(posedge clock) disable iff (!arst_n)
		$rose(out_valid) |-> $past(busy));

endmodule

`default_nettype wire

/* dfg_kernel.f */
+incdir+verification
common/fpk_pkg.sv
fpu_add/fpu_add.sv
fpu_mul/fpu_mul.sv
design/delay_line.sv
design/kernel_control.sv
design/dfg_kernel.sv
verification/dfg_kernel_tb.sv

/* fpu_add/fpu_add.sv */
// Round-to-nearest-even binary32 adder, 3 cycles. Subnormals read and write as +0 and NaN or infinity inputs are not handled
`timescale 1ns/1ps
`default_nettype none

module fpu_add (
	input  wire          clock,
	input  wire          arst_n,
	input  wire  fpk_pkg::fp_t opa,
	input  wire  fpk_pkg::fp_t opb,
	output fpk_pkg::fp_t sum
);
	import fpk_pkg::*;

	fp_t                      fa;
	fp_t                      fb;
	fp_t                      big;
	fp_t                      lesser;
	logic                     swap;
	logic [EXP_W-1:0]         ediff;
	logic [EXP_W-1:0]         shamt;
	logic [2*MANT_W+1:0]      b_wide;

	logic                     s1_sign;
	logic                     s1_sub;
	logic [EXP_W-1:0]         s1_exp;
	logic [EXT_W-1:0]         s1_ma;
	logic [EXT_W-1:0]         s1_mb;

	logic [EXT_W:0]           raw;
	logic [4:0]               lz;
	logic [EXT_W-1:0]         norm;
	logic signed [SEXP_W-1:0] nexp;

	logic                     s2_sign;
	logic                     s2_zero;
	logic signed [SEXP_W-1:0] s2_exp;
	logic [EXT_W-1:0]         s2_mant;

	logic                     round_up;
	logic [MANT_W:0]          rnd;
	logic signed [SEXP_W-1:0] rexp;
	fp_t                      res;

	// leading zeros of the raw sum, EXT_W when it is zero
	function automatic logic [4:0] lzc(input logic [EXT_W-1:0] v);
		logic [4:0] n;
		logic       found;
		n = '0;
		found = 1'b0;
		for (int i = EXT_W - 1; i >= 0; i--)
		begin
			if (v[i])
				found = 1'b1;
			else if (!found)
				n = n + 5'd1;
		end
		return n;
	endfunction

	// stage one: order by magnitude and align the smaller operand
	always_comb
	begin
		fa = opa;
		fb = opb;
		if (opa.exp == '0)
			fa.frac = '0;
		if (opb.exp == '0)
			fb.frac = '0;
		swap = {fb.exp, fb.frac} > {fa.exp, fa.frac};
		big = swap ? fb : fa;
		lesser = swap ? fa : fb;
		ediff = big.exp - lesser.exp;
		// anything shifted past the round bit only feeds sticky
		shamt = (ediff > EXP_W'(MANT_W + 2)) ? EXP_W'(MANT_W + 2) : ediff;
		b_wide = {lesser.exp != '0, lesser.frac, {(MANT_W + 2){1'b0}}} >> shamt;
	end

	always_ff @(posedge clock)
	begin
		s1_sign <= big.sign;
		s1_sub <= fa.sign ^ fb.sign;
		s1_exp <= big.exp;
		s1_ma <= {big.exp != '0, big.frac, 3'b000};
		s1_mb <= {b_wide[2*MANT_W+1:MANT_W], |b_wide[MANT_W-1:0]};
	end

	// stage two: add or subtract, then normalize
	always_comb
	begin
		if (s1_sub)
			raw = {1'b0, s1_ma} - {1'b0, s1_mb};
		else
			raw = {1'b0, s1_ma} + {1'b0, s1_mb};
		lz = lzc(raw[EXT_W-1:0]);
		if (raw[EXT_W])
		begin
			// carry out, keep the dropped bit in sticky
			norm = {raw[EXT_W:2], raw[1] | raw[0]};
			nexp = SEXP_W'(s1_exp) + SEXP_W'(1);
		end
		else
		begin
			norm = raw[EXT_W-1:0] << lz;
			nexp = SEXP_W'(s1_exp) - SEXP_W'(lz);
		end
	end

	always_ff @(posedge clock)
	begin
		s2_sign <= s1_sign;
		s2_zero <= raw == '0;
		s2_exp <= nexp;
		s2_mant <= norm;
	end

	// stage three: round to nearest even, then zero, flush and overflow
	always_comb
	begin
		round_up = s2_mant[2] & (s2_mant[1] | s2_mant[0] | s2_mant[3]);
		rnd = {1'b0, s2_mant[EXT_W-1:3]} + {{MANT_W{1'b0}}, round_up};
		rexp = s2_exp + SEXP_W'(rnd[MANT_W]);
		if (s2_zero || rexp <= SEXP_W'(0))
			res = '0;
		else if (rexp >= SEXP_W'(EXP_INF))
			res = '{sign: s2_sign, exp: '1, frac: '0};
		else
			res = '{sign: s2_sign, exp: rexp[EXP_W-1:0], frac: rnd[FRAC_W-1:0]};
	end

	always_ff @(posedge clock)
	begin
		sum <= res;
	end

	// two zero operands always give +0, whatever their signs
	zero_sum_is_pos_zero: assert property (@(posedge clock) disable iff (!arst_n)
		(opa.exp == '0 && opb.exp == '0) |-> ##ADD_LAT (sum == '0));

endmodule

`default_nettype wire

/* fpu_mul/fpu_mul.sv */
// Round-to-nearest-even binary32 multiplier, 2 cycles. Subnormals read and write as +0 and NaN or infinity inputs are not handled
`timescale 1ns/1ps
`default_nettype none

module fpu_mul (
	input  wire          clock,
	input  wire          arst_n,
	input  wire  fpk_pkg::fp_t opa,
	input  wire  fpk_pkg::fp_t opb,
	output fpk_pkg::fp_t product
);
	import fpk_pkg::*;

	logic                     s1_sign;
	logic                     s1_zero;
	logic signed [SEXP_W-1:0] s1_exp;
	logic [2*MANT_W-1:0]      s1_prod;

	logic [MANT_W-1:0]        mant;
	logic                     guard;
	logic                     sticky;
	logic signed [SEXP_W-1:0] nexp;
	logic [MANT_W:0]          rnd;
	logic signed [SEXP_W-1:0] rexp;
	fp_t                      res;

	// stage one: sign, biased exponent sum and full mantissa product
	always_ff @(posedge clock)
	begin
		s1_sign <= opa.sign ^ opb.sign;
		s1_zero <= (opa.exp == '0) || (opb.exp == '0);
		s1_exp <= SEXP_W'(opa.exp) + SEXP_W'(opb.exp) - SEXP_W'(EXP_BIAS);
		s1_prod <= (2*MANT_W)'({1'b1, opa.frac}) * (2*MANT_W)'({1'b1, opb.frac});
	end

	// stage two: the product lies in [1, 4) so at most one shift is needed
	always_comb
	begin
		if (s1_prod[2*MANT_W-1])
		begin
			mant = s1_prod[2*MANT_W-1 -: MANT_W];
			guard = s1_prod[MANT_W-1];
			sticky = |s1_prod[MANT_W-2:0];
			nexp = s1_exp + SEXP_W'(1);
		end
		else
		begin
			mant = s1_prod[2*MANT_W-2 -: MANT_W];
			guard = s1_prod[MANT_W-2];
			sticky = |s1_prod[MANT_W-3:0];
			nexp = s1_exp;
		end
		rnd = {1'b0, mant} + {{MANT_W{1'b0}}, guard & (sticky | mant[0])};
		// rounding carry leaves an all-zero fraction
		rexp = nexp + SEXP_W'(rnd[MANT_W]);
		if (s1_zero || rexp <= SEXP_W'(0))
			res = '0;
		else if (rexp >= SEXP_W'(EXP_INF))
			res = '{sign: s1_sign, exp: '1, frac: '0};
		else
			res = '{sign: s1_sign, exp: rexp[EXP_W-1:0], frac: rnd[FRAC_W-1:0]};
	end

	always_ff @(posedge clock)
	begin
		product <= res;
	end

	// only a flushed or exact zero may lose the sign of the operands
	product_sign: assert property (@(posedge clock) disable iff (!arst_n)
		(product != '0) |-> (product.sign == $past(opa.sign ^ opb.sign, MUL_LAT)));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the dfg_kernel testbench with Verilator, log goes to sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module dfg_kernel_tb -f dfg_kernel.f -o dfg_kernel_sim

./obj_dir/dfg_kernel_sim > sim.log 2>&1

if grep -qF "** FAIL **" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"

/* verification/fp_model.svh */
// Binary32 reference on reals with flush to zero. Exact only while every sum and product fits a double
`ifndef FP_MODEL_SVH
`define FP_MODEL_SVH

// subnormal operands read as zero
function automatic real fp_to_real(input fp_t f);
	real m;
	m = (f.exp == '0) ? 0.0 : real'({1'b1, f.frac});
	// scale the integer mantissa by 2^(exp - bias - 23)
	for (int i = 0; i < int'(f.exp) - EXP_BIAS - FRAC_W; i++)
		m = m * 2.0;
	for (int i = 0; i > int'(f.exp) - EXP_BIAS - FRAC_W; i--)
		m = m / 2.0;
	return f.sign ? -m : m;
endfunction

function automatic fp_t real_to_fp(input real r);
	real a;
	real rem;
	int e;
	int mi;
	fp_t f;
	f = '0;
	a = (r < 0.0) ? -r : r;
	// bring the magnitude into [2^23, 2^24), e tracks the biased exponent
	e = EXP_BIAS + FRAC_W;
	while (a >= 16777216.0)
	begin
		a = a / 2.0;
		e++;
	end
	while (a > 0.0 && a < 8388608.0)
	begin
		a = a * 2.0;
		e--;
	end
	mi = $rtoi(a);
	rem = a - $itor(mi);
	// nearest, ties to even
	if (rem > 0.5 || (rem == 0.5 && mi[0]))
		mi++;
	if (mi == 16777216)
	begin
		mi = mi / 2;
		e++;
	end
	// exact zero and tiny results give +0
	if (a == 0.0 || e <= 0)
		return f;
	f.sign = r < 0.0;
	f.exp = (e >= EXP_INF) ? '1 : e[EXP_W-1:0];
	f.frac = (e >= EXP_INF) ? '0 : mi[FRAC_W-1:0];
	return f;
endfunction

function automatic fp_t fp_add_ref(input fp_t a, input fp_t b);
	return real_to_fp(fp_to_real(a) + fp_to_real(b));
endfunction

function automatic fp_t fp_mul_ref(input fp_t a, input fp_t b);
	return real_to_fp(fp_to_real(a) * fp_to_real(b));
endfunction

`endif

/* verification/dfg_kernel_tb.sv */
// Random and directed testbench for dfg_kernel. Operands stay normal and finite, exponents 120 to 134
`timescale 1ns/1ps
`default_nettype none

module dfg_kernel_tb;
	import fpk_pkg::*;

	localparam int PERIOD = 20;
	localparam int RESET_CYCLES = 5;
	// results leave a fixed number of cycles after their sample
	localparam int LATENCY = 8;
	localparam int BURST_N = 200;
	localparam int GAP_N = 40;
	localparam int MAX_GAP = 3;
	localparam int DIRECTED_N = 5;
	// every phase at its longest, then drain and slack
	localparam int RUN_CYCLES = RESET_CYCLES + BURST_N + GAP_N * (MAX_GAP + 1) + DIRECTED_N
		+ LATENCY + 50;

	logic               clock;
	logic               arst_n;
	logic               in_valid;
	fp_sample_t         sample;
	fp_result_t         result;
	logic               out_valid;
	logic               busy;
	logic [COUNT_W-1:0] sample_count;

	// expected results and due cycles of samples in flight
	fp_result_t exp_q[$];
	int         due_q[$];
	fp_result_t model_out;
	int         cycle = 0;
	int         errors = 0;
	int         driven = 0;
	int         pulses = 0;

	`include "fp_model.svh"

	dfg_kernel dut (.*);

	// the graph, rounded after every operation
	function automatic fp_result_t kernel_ref(input fp_sample_t s);
		fp_result_t r;
		fp_t        x1;
		fp_t        add2;
		x1 = fp_mul_ref(fp_mul_ref(s.in3, s.in1), s.in1);
		add2 = fp_add_ref(fp_add_ref(s.in5, s.in4), fp_add_ref(s.in2, s.in4));
		r.result_1 = fp_mul_ref(x1, add2);
		r.result_2 = fp_add_ref(s.in1, s.in2);
		r.result_3 = fp_add_ref(s.in5, s.in3);
		r.result_4 = fp_mul_ref(s.in5, s.in4);
		return r;
	endfunction

	function automatic fp_t rand_fp();
		return {1'($urandom), 8'(120 + $urandom % 15), 23'($urandom)};
	endfunction

	function automatic fp_sample_t rand_sample();
		return {rand_fp(), rand_fp(), rand_fp(), rand_fp(), rand_fp()};
	endfunction

	task automatic check(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// called 2 ns after a rising edge, returns 2 ns after the next one
	task automatic drive_sample(input fp_sample_t s);
		sample = s;
		in_valid = 1'b1;
		exp_q.push_back(kernel_ref(s));
		due_q.push_back(cycle + LATENCY);
		driven++;
		@(posedge clock);
		#2;
		in_valid = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clock);
			#2;
		end
	endtask

	initial
	begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	always @(posedge clock)
		cycle <= cycle + 1;

	// outputs are sampled on the falling edge, away from the updates
	always @(negedge clock)
	begin
		if (arst_n && out_valid)
		begin
			pulses++;
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("error: out_valid at %0t ns with no sample in flight", $time);
			end
			else
			begin
				model_out = exp_q.pop_front();
				check("out_valid cycle", cycle, due_q.pop_front());
				check("result_1", result.result_1, model_out.result_1);
				check("result_2", result.result_2, model_out.result_2);
				check("result_3", result.result_3, model_out.result_3);
				check("result_4", result.result_4, model_out.result_4);
			end
		end
	end

	initial
	begin : stimulus
		fp_sample_t s;
		arst_n = 1'b0;
		in_valid = 1'b0;
		sample = '0;
		void'($urandom(32'hab7e));
		repeat (RESET_CYCLES) @(posedge clock);
		#2;
		arst_n = 1'b1;
		@(negedge clock);
		check("out_valid after reset", 32'(out_valid), 0);
		check("busy after reset", 32'(busy), 0);
		check("sample_count after reset", sample_count, 0);
		@(posedge clock);
		#2;

		repeat (BURST_N)
			drive_sample(rand_sample());

		repeat (GAP_N)
		begin
			drive_sample(rand_sample());
			idle(int'($urandom % (MAX_GAP + 1)));
		end

		// in2 = -in4 and in5 = -in3, so result_3 is an exact +0
		s = rand_sample();
		s.in2 = s.in4;
		s.in2.sign = ~s.in4.sign;
		s.in5 = s.in3;
		s.in5.sign = ~s.in3.sign;
		drive_sample(s);
		// in5 = -in4 as well, add2 cancels and result_1 goes to zero
		s.in5 = s.in4;
		s.in5.sign = ~s.in4.sign;
		drive_sample(s);

		// ties for the adder (down to even, up to even) and a tie up in the multiplier
		drive_sample({32'h3f800000, 32'h33800000, 32'h33800000, 32'h3fc00000, 32'h3f800001});
		// rounding carry in the adder (2 - 2^-23 plus half an ulp), tie down in the multiplier
		drive_sample({32'h3fffffff, 32'h33800000, 32'h3fc00000, 32'h3f800800, 32'h3f800800});
		// carry out of the adder sum and of the multiplier product
		drive_sample({32'h3fc00000, 32'h3fc00000, 32'h3fc00000, 32'h3fc00000, 32'h3fc00000});

		while (exp_q.size() != 0)
			@(posedge clock);
		@(negedge clock);
		check("busy after last result", 32'(busy), 0);
		check("sample_count at end", sample_count, driven);
		check("out_valid pulses at end", pulses, driven);

		$display("errors: %0d, samples driven: %0d, results seen: %0d", errors, driven, pulses);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin
		#(RUN_CYCLES * PERIOD);
		$display("timeout: the run did not finish within %0d clock cycles", RUN_CYCLES);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire
